/* include/core_settings.svh */
// Core settings
// Widths, memory depths, the NOP word and the reported register set
// shared by the RV32I pipeline

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define CORE_XLEN             32
`define CORE_IMEM_WORDS_LOG2  6
`define CORE_DMEM_WORDS_LOG2  6
`define CORE_APB_ADDR_BITS    12

`define CORE_NOP              32'h0000_0013   // ADDI x0,x0,0

// Registers whose writes go out on the result port
`define CORE_RESULT_LO        18
`define CORE_RESULT_HI        25
`define CORE_RESULT_EXTRA     9

`endif

/* src/isa_pkg.sv */
// RV32I instruction encoding
// Instruction and register index types, the major opcodes kept by the
// core and the funct3/funct7 codes of the supported operations

package isa_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [6:0] {
    OP_REG    = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_t;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_ADDI    = 3'b000;
  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_ALT     = 7'b0100000;   // SUB

endpackage

/* src/pipe_pkg.sv */
// Pipeline types
// Data word and program counter types plus the ALU and branch control
// encodings carried from decode into execute

`include "core_settings.svh"

package pipe_pkg;

  typedef logic [`CORE_XLEN-1:0]              word_t;
  typedef logic [`CORE_IMEM_WORDS_LOG2+1:0]   pc_t;     // Byte address

  // LINK returns pc + 4 for JAL
  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LINK
  } alu_op_t;

  typedef enum logic [1:0] {
    BR_NONE, BR_EQ, BR_NE, BR_JUMP
  } branch_kind_t;

endpackage

/* src/imem_apb.sv */
// Instruction memory
// Loaded and read back over an APB slave port, read combinationally by
// fetch. Writes are refused while the core runs

`timescale 1ns/10ps
`include "core_settings.svh"

module imem_apb import isa_pkg::*, pipe_pkg::*; (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            start,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [`CORE_APB_ADDR_BITS-1:0]  paddr,
  input  instr_t                          pwdata,
  output instr_t                          prdata,
  output logic                            pready,
  output logic                            pslverr,
  input  pc_t                             fetch_pc,
  output instr_t                          fetch_instr
);

  localparam int unsigned DEPTH = 2 ** `CORE_IMEM_WORDS_LOG2;

  instr_t                          mem [DEPTH];
  logic [`CORE_IMEM_WORDS_LOG2-1:0] apb_idx;
  logic                            out_of_range;
  logic                            setup;
  logic                            access;
  logic                            err_q;     // Decided in SETUP
  instr_t                          rdata_q;

  assign apb_idx      = paddr[`CORE_IMEM_WORDS_LOG2+1:2];
  assign out_of_range = |paddr[`CORE_APB_ADDR_BITS-1:`CORE_IMEM_WORDS_LOG2+2];
  assign setup        = psel & ~penable;
  assign access       = psel & penable;

  always_ff @(posedge clock) begin
    if (reset) begin
      err_q <= 1'b0;
    end else begin
      err_q <= setup & (out_of_range | (pwrite & start));
    end
  end

  always_ff @(posedge clock) begin
    if (setup) begin
      rdata_q <= mem[apb_idx];
    end
    if (access && pwrite && !err_q) begin
      mem[apb_idx] <= pwdata;
    end
  end

  assign prdata      = rdata_q;
  assign pready      = 1'b1;                  // No wait states
  assign pslverr     = err_q & access;
  assign fetch_instr = mem[fetch_pc[`CORE_IMEM_WORDS_LOG2+1:2]];

endmodule

/* src/fetch_stage.sv */
// Fetch stage
// Program counter and the IF/ID register. Always predicts not-taken and
// takes the resolved target from execute on a redirect

`timescale 1ns/10ps
`include "core_settings.svh"

module fetch_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic   clock,
  input  logic   reset,
  input  logic   start,
  input  logic   stall,
  input  logic   redirect,
  input  pc_t    redirect_pc,
  input  instr_t fetch_instr,
  output pc_t    fetch_pc,
  output pc_t    id_pc,
  output instr_t id_instr
);

  pc_t pc;

  assign fetch_pc = pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc       <= '0;
      id_pc    <= '0;
      id_instr <= `CORE_NOP;
    end else if (redirect) begin
      pc       <= redirect_pc;            // Squash the wrong-path fetch
      id_pc    <= '0;
      id_instr <= `CORE_NOP;
    end else if (!stall) begin
      if (start) begin
        pc       <= pc + pc_t'(4);
        id_pc    <= pc;
        id_instr <= fetch_instr;
      end else begin
        id_instr <= `CORE_NOP;            // Idle, PC holds
      end
    end
  end

endmodule

/* src/decode_stage.sv */
// Decode stage
// Register file, control and immediate decode, load-use hazard detection
// and the ID/EX register. Branch and JAL targets are formed here

`timescale 1ns/10ps

module decode_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         redirect,
  input  pc_t          id_pc,
  input  instr_t       id_instr,
  input  logic         wb_write,
  input  reg_idx_t     wb_rd,
  input  word_t        wb_data,
  output logic         stall,
  output pc_t          ex_pc,
  output reg_idx_t     ex_rs1,
  output reg_idx_t     ex_rs2,
  output reg_idx_t     ex_rd,
  output word_t        ex_rs1_data,
  output word_t        ex_rs2_data,
  output word_t        ex_imm,
  output alu_op_t      ex_alu_op,
  output logic         ex_b_is_imm,
  output branch_kind_t ex_branch,
  output logic         ex_reg_write,
  output logic         ex_mem_read,
  output logic         ex_mem_write
);

  word_t        regs [32];
  opcode_t      opcode;
  logic [2:0]   funct3;
  logic [6:0]   funct7;
  reg_idx_t     rs1, rs2;
  word_t        rs1_data, rs2_data;
  word_t        imm_i, imm_s, br_target, jal_target;
  alu_op_t      d_alu_op;
  branch_kind_t d_branch;
  word_t        d_imm;
  logic         d_b_is_imm, d_reg_write, d_mem_read, d_mem_write;
  logic         d_use_rs1, d_use_rs2;
  logic         bubble;

  assign opcode = opcode_t'(id_instr[6:0]);
  assign funct3 = id_instr[14:12];
  assign funct7 = id_instr[31:25];

  // Unused source fields read as x0 so they never raise a hazard
  assign rs1 = d_use_rs1 ? id_instr[19:15] : '0;
  assign rs2 = d_use_rs2 ? id_instr[24:20] : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Register file, write-through on the writeback port
  always_ff @(posedge clock) begin
    if (wb_write && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : (wb_write && wb_rd == rs1) ? wb_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : (wb_write && wb_rd == rs2) ? wb_data : regs[rs2];

  ////////////////////////////////////////////////////////////////////////////
  // Immediates and targets
  assign imm_i      = {{20{id_instr[31]}}, id_instr[31:20]};
  assign imm_s      = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
  assign br_target  = word_t'(id_pc) + {{19{id_instr[31]}}, id_instr[31], id_instr[7],
                                         id_instr[30:25], id_instr[11:8], 1'b0};
  assign jal_target = word_t'(id_pc) + {{11{id_instr[31]}}, id_instr[31], id_instr[19:12],
                                         id_instr[20], id_instr[30:21], 1'b0};

  always_comb begin
    d_alu_op    = ALU_ADD;
    d_branch    = BR_NONE;
    d_imm       = imm_i;
    d_b_is_imm  = 1'b0;
    d_reg_write = 1'b0;
    d_mem_read  = 1'b0;
    d_mem_write = 1'b0;
    d_use_rs1   = 1'b0;
    d_use_rs2   = 1'b0;
    case (opcode)
      OP_REG: begin
        d_use_rs1   = 1'b1;
        d_use_rs2   = 1'b1;
        d_reg_write = (funct7 == F7_BASE) || (funct7 == F7_ALT && funct3 == F3_ADD_SUB);
        case (funct3)
          F3_ADD_SUB: d_alu_op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
          F3_SLT:     d_alu_op = ALU_SLT;
          F3_XOR:     d_alu_op = ALU_XOR;
          F3_OR:      d_alu_op = ALU_OR;
          F3_AND:     d_alu_op = ALU_AND;
          default:    d_reg_write = 1'b0;   // SLL, SLTU and shifts dropped
        endcase
      end
      OP_IMM, OP_LOAD: begin
        if (funct3 == (opcode == OP_LOAD ? F3_LW : F3_ADDI)) begin
          d_use_rs1   = 1'b1;
          d_b_is_imm  = 1'b1;
          d_reg_write = 1'b1;
          d_mem_read  = (opcode == OP_LOAD);
        end
      end
      OP_STORE: begin
        d_use_rs1   = (funct3 == F3_SW);
        d_use_rs2   = (funct3 == F3_SW);
        d_b_is_imm  = 1'b1;
        d_mem_write = (funct3 == F3_SW);
        d_imm       = imm_s;
      end
      OP_BRANCH: begin
        d_imm = br_target;
        if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
          d_use_rs1 = 1'b1;
          d_use_rs2 = 1'b1;
          d_branch  = (funct3 == F3_BEQ) ? BR_EQ : BR_NE;
        end
      end
      OP_JAL: begin
        d_alu_op    = ALU_LINK;
        d_branch    = BR_JUMP;
        d_imm       = jal_target;
        d_reg_write = 1'b1;
      end
      default: ;                            // Anything else is a NOP
    endcase
  end

  // Load-use hazard against the instruction now in ID/EX
  assign stall  = ex_mem_read && ex_rd != '0 && (ex_rd == rs1 || ex_rd == rs2) && !redirect;
  assign bubble = stall | redirect;

  ////////////////////////////////////////////////////////////////////////////
  // ID/EX register
  always_ff @(posedge clock) begin
    if (reset || bubble) begin
      ex_rs1       <= '0;
      ex_rs2       <= '0;
      ex_rd        <= '0;
      ex_branch    <= BR_NONE;
      ex_reg_write <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
    end else begin
      ex_rs1       <= rs1;
      ex_rs2       <= rs2;
      ex_rd        <= id_instr[11:7];
      ex_branch    <= d_branch;
      ex_reg_write <= d_reg_write;
      ex_mem_read  <= d_mem_read;
      ex_mem_write <= d_mem_write;
    end
  end

  always_ff @(posedge clock) begin
    ex_pc       <= id_pc;
    ex_rs1_data <= rs1_data;
    ex_rs2_data <= rs2_data;
    ex_imm      <= d_imm;
    ex_alu_op   <= d_alu_op;
    ex_b_is_imm <= d_b_is_imm;
  end

endmodule

/* src/execute_stage.sv */
// Execute stage
// Operand forwarding, the ALU and branch resolution. Registers the result
// and any redirect into EX/MEM

`timescale 1ns/10ps

module execute_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  pc_t          ex_pc,
  input  reg_idx_t     ex_rs1,
  input  reg_idx_t     ex_rs2,
  input  reg_idx_t     ex_rd,
  input  word_t        ex_rs1_data,
  input  word_t        ex_rs2_data,
  input  word_t        ex_imm,
  input  alu_op_t      ex_alu_op,
  input  logic         ex_b_is_imm,
  input  branch_kind_t ex_branch,
  input  logic         ex_reg_write,
  input  logic         ex_mem_read,
  input  logic         ex_mem_write,
  input  logic         wb_write,
  input  reg_idx_t     wb_rd,
  input  word_t        wb_data,
  output logic         redirect,
  output pc_t          redirect_pc,
  output word_t        mem_alu_result,
  output word_t        mem_store_data,
  output reg_idx_t     mem_rd,
  output logic         mem_reg_write,
  output logic         mem_mem_read,
  output logic         mem_mem_write
);

  word_t op_a, op_b_reg, op_b, alu_result;
  logic  taken;

  // EX/MEM wins over writeback, x0 never forwarded
  assign op_a     = (mem_reg_write && mem_rd == ex_rs1 && ex_rs1 != '0) ? mem_alu_result :
                    (wb_write && wb_rd == ex_rs1 && ex_rs1 != '0) ? wb_data : ex_rs1_data;
  assign op_b_reg = (mem_reg_write && mem_rd == ex_rs2 && ex_rs2 != '0) ? mem_alu_result :
                    (wb_write && wb_rd == ex_rs2 && ex_rs2 != '0) ? wb_data : ex_rs2_data;
  assign op_b     = ex_b_is_imm ? ex_imm : op_b_reg;

  always_comb begin
    case (ex_alu_op)
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_AND:  alu_result = op_a & op_b;
      ALU_OR:   alu_result = op_a | op_b;
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_SLT:  alu_result = word_t'($signed(op_a) < $signed(op_b));
      ALU_LINK: alu_result = word_t'(ex_pc + pc_t'(4));   // Return address
      default:  alu_result = op_a + op_b;
    endcase
  end

  always_comb begin
    case (ex_branch)
      BR_EQ:   taken = (op_a == op_b_reg);
      BR_NE:   taken = (op_a != op_b_reg);
      BR_JUMP: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX/MEM register, bubble behind a redirect
  always_ff @(posedge clock) begin
    if (reset || redirect) begin
      redirect      <= 1'b0;
      mem_rd        <= '0;
      mem_reg_write <= 1'b0;
      mem_mem_read  <= 1'b0;
      mem_mem_write <= 1'b0;
    end else begin
      redirect      <= taken;
      mem_rd        <= ex_rd;
      mem_reg_write <= ex_reg_write;
      mem_mem_read  <= ex_mem_read;
      mem_mem_write <= ex_mem_write;
    end
  end

  always_ff @(posedge clock) begin
    redirect_pc    <= ex_imm[$bits(pc_t)-1:0];   // Target formed in decode
    mem_alu_result <= alu_result;
    mem_store_data <= op_b_reg;
  end

endmodule

/* src/memory_writeback.sv */
// Memory and writeback
// Word-wide data memory, the MEM/WB register, writeback select and the
// result port for the saved registers

`timescale 1ns/10ps
`include "core_settings.svh"

module memory_writeback import isa_pkg::*, pipe_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  word_t    mem_alu_result,
  input  word_t    mem_store_data,
  input  reg_idx_t mem_rd,
  input  logic     mem_reg_write,
  input  logic     mem_mem_read,
  input  logic     mem_mem_write,
  output logic     wb_write,
  output reg_idx_t wb_rd,
  output word_t    wb_data,
  output logic     result_valid,
  output reg_idx_t result_reg,
  output word_t    result_data
);

  localparam int unsigned DMEM_DEPTH = 2 ** `CORE_DMEM_WORDS_LOG2;

  word_t                            dmem [DMEM_DEPTH];
  logic [`CORE_DMEM_WORDS_LOG2-1:0] dmem_idx;
  logic                             wb_is_load;
  word_t                            wb_alu, wb_load;
  logic                             reportable;

  assign dmem_idx = mem_alu_result[`CORE_DMEM_WORDS_LOG2+1:2];

  always_ff @(posedge clock) begin
    if (mem_mem_write) begin
      dmem[dmem_idx] <= mem_store_data;
    end
    wb_alu  <= mem_alu_result;
    wb_load <= dmem[dmem_idx];
  end

  // MEM/WB control
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_write   <= 1'b0;
      wb_rd      <= '0;
      wb_is_load <= 1'b0;
    end else begin
      wb_write   <= mem_reg_write;
      wb_rd      <= mem_rd;
      wb_is_load <= mem_mem_read;
    end
  end

  assign wb_data = wb_is_load ? wb_load : wb_alu;

  ////////////////////////////////////////////////////////////////////////////
  // Result port, s1 and s2-s9
  assign reportable = (wb_rd == reg_idx_t'(`CORE_RESULT_EXTRA)) ||
                      (wb_rd >= reg_idx_t'(`CORE_RESULT_LO) &&
                       wb_rd <= reg_idx_t'(`CORE_RESULT_HI));

  always_ff @(posedge clock) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= wb_write && reportable;
    end
    result_reg  <= wb_rd;
    result_data <= wb_data;
  end

endmodule

/* src/riscv_core.sv */
// RV32I core top level
// Five-stage in-order pipeline with an APB-loaded instruction memory and
// a result port for writes to the saved registers

`timescale 1ns/10ps
`include "core_settings.svh"

module riscv_core import isa_pkg::*, pipe_pkg::*; (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            start,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [`CORE_APB_ADDR_BITS-1:0]  paddr,
  input  instr_t                          pwdata,
  output instr_t                          prdata,
  output logic                            pready,
  output logic                            pslverr,
  output logic                            result_valid,
  output reg_idx_t                        result_reg,
  output word_t                           result_data
);

  // Fetch and IF/ID
  pc_t          fetch_pc, id_pc;
  instr_t       fetch_instr, id_instr;
  logic         stall;

  // ID/EX
  pc_t          ex_pc;
  reg_idx_t     ex_rs1, ex_rs2, ex_rd;
  word_t        ex_rs1_data, ex_rs2_data, ex_imm;
  alu_op_t      ex_alu_op;
  logic         ex_b_is_imm;
  branch_kind_t ex_branch;
  logic         ex_reg_write, ex_mem_read, ex_mem_write;

  // EX/MEM
  logic         redirect;
  pc_t          redirect_pc;
  word_t        mem_alu_result, mem_store_data;
  reg_idx_t     mem_rd;
  logic         mem_reg_write, mem_mem_read, mem_mem_write;

  // Writeback
  logic         wb_write;
  reg_idx_t     wb_rd;
  word_t        wb_data;

  ////////////////////////////////////////////////////////////////////////////
  // Stages, connected by matching names
  imem_apb         imem_apb_inst         (.*);
  fetch_stage      fetch_stage_inst      (.*);
  decode_stage     decode_stage_inst     (.*);
  execute_stage    execute_stage_inst    (.*);
  memory_writeback memory_writeback_inst (.*);

endmodule

/* testbench/core_assert.sv */
// Core assertions
// APB error, result port and hazard rules, bound onto the core top level

`timescale 1ns/10ps
`include "core_settings.svh"

module core_assert import isa_pkg::*; (
  input logic     clock,
  input logic     reset,
  input logic     penable,
  input logic     pslverr,
  input logic     result_valid,
  input reg_idx_t result_reg,
  input logic     stall,
  input logic     redirect
);

  logic reported;   // s1 or s2-s9

  assign reported = (result_reg == reg_idx_t'(`CORE_RESULT_EXTRA)) ||
                    (result_reg >= reg_idx_t'(`CORE_RESULT_LO) &&
                     result_reg <= reg_idx_t'(`CORE_RESULT_HI));

  pslverr_in_access: assert property (
    @(posedge clock) disable iff (reset) pslverr |-> penable
  ) else $error("pslverr high outside an ACCESS cycle");

  result_in_set: assert property (
    @(posedge clock) disable iff (reset) result_valid |-> reported
  ) else $error("result port reported a register outside the set");

  // A squash already empties decode
  no_stall_on_redirect: assert property (
    @(posedge clock) disable iff (reset) !(stall && redirect)
  ) else $error("stall and redirect high together");

endmodule

bind riscv_core core_assert core_assert_inst (
  .clock        (clock),
  .reset        (reset),
  .penable      (penable),
  .pslverr      (pslverr),
  .result_valid (result_valid),
  .result_reg   (result_reg),
  .stall        (stall),
  .redirect     (redirect)
);

/* testbench/core_tb.sv */
// Testbench for the RV32I pipeline core
// Loads small programs over APB, runs them and checks every write that
// appears on the result port against hand-worked values

`timescale 1ns/10ps
`include "core_settings.svh"

module core_tb;

  localparam int APB_TIMEOUT  = 16;
  localparam int PROG_TIMEOUT = 2000;
  localparam int NUM_PROGS    = 4;
  localparam int IMEM_WORDS   = 2 ** `CORE_IMEM_WORDS_LOG2;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [6:0] F7_BASE = 7'h00;
  localparam logic [6:0] F7_SUB  = 7'h20;

  logic                           clock;
  logic                           reset;
  logic                           start;
  logic                           psel;
  logic                           penable;
  logic                           pwrite;
  logic [`CORE_APB_ADDR_BITS-1:0] paddr;
  logic [31:0]                    pwdata;
  logic [31:0]                    prdata;
  logic                           pready;
  logic                           pslverr;
  logic                           result_valid;
  logic [4:0]                     result_reg;
  logic [31:0]                    result_data;

  // Program words and expected results with one row each
  int          prog_num_q[$];
  logic [31:0] prog_word_q[$];
  int          exp_num_q[$];
  logic [31:0] exp_reg_q[$];
  logic [31:0] exp_val_q[$];

  int exp_ptr;        // Next expected row
  int exp_end;        // One past the current program's rows
  int errors;
  int tests_failed;
  bit hung;

  riscv_core riscv_core_inst (.*);

  always #50 clock = ~clock;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encoders for the RV32I formats
  function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
  endfunction

  function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
    return {12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
  endfunction

  function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
    logic [11:0] i;
    i = 12'(imm);
    return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input int rs1, input int rs2,
                                         input int off);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal(input int rd, input int off);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
  endfunction

  // ADDI x0,x0,addr so a running core ignores it
  function automatic logic [31:0] fill_word(input logic [11:0] addr);
    return {addr, 20'h00013};
  endfunction

  function automatic void add_word(input int p, input logic [31:0] w);
    prog_num_q.push_back(p);
    prog_word_q.push_back(w);
  endfunction

  function automatic void add_result(input int p, input int r, input logic [31:0] v);
    exp_num_q.push_back(p);
    exp_reg_q.push_back(32'(r));
    exp_val_q.push_back(v);
  endfunction

  function automatic string test_title(input int t);
    case (t)
      0:       return "APB load and readback";
      1:       return "dependent ALU chain";
      2:       return "store, load and load-use";
      3:       return "branches and jump";
      default: return "result filtering";
    endcase
  endfunction

  task automatic build_tables();
    // Program 1 runs a wraparound ALU chain through both forwarding paths
    add_word(1, addi(18, 0, 100));
    add_word(1, addi(19, 0, -7));
    add_word(1, alu_rr(F7_BASE, F3_ADD, 20, 18, 19));
    add_word(1, alu_rr(F7_SUB, F3_ADD, 21, 19, 18));
    add_word(1, alu_rr(F7_BASE, F3_AND, 22, 20, 21));
    add_word(1, alu_rr(F7_BASE, F3_OR, 23, 20, 19));
    add_word(1, alu_rr(F7_BASE, F3_XOR, 24, 23, 18));
    add_word(1, alu_rr(F7_BASE, F3_SLT, 25, 21, 20));
    add_word(1, alu_rr(F7_BASE, F3_SLT, 9, 20, 21));
    add_result(1, 18, 32'h0000_0064);
    add_result(1, 19, 32'hFFFF_FFF9);
    add_result(1, 20, 32'h0000_005D);
    add_result(1, 21, 32'hFFFF_FF95);
    add_result(1, 22, 32'h0000_0015);
    add_result(1, 23, 32'hFFFF_FFFD);
    add_result(1, 24, 32'hFFFF_FF99);
    add_result(1, 25, 32'h0000_0001);
    add_result(1, 9,  32'h0000_0000);
    // Program 2 stores, loads and uses the load at once
    add_word(2, addi(18, 0, 291));
    add_word(2, addi(6, 0, 16));
    add_word(2, sw(18, 6, 4));
    add_word(2, lw(19, 6, 4));
    add_word(2, alu_rr(F7_BASE, F3_ADD, 20, 19, 18));
    add_result(2, 18, 32'h0000_0123);
    add_result(2, 19, 32'h0000_0123);
    add_result(2, 20, 32'h0000_0246);
    // Program 3 has a taken BEQ, a not-taken BNE and a JAL
    add_word(3, addi(18, 0, 5));
    add_word(3, addi(19, 0, 5));
    add_word(3, branch(F3_BEQ, 18, 19, 12));    // To 20
    add_word(3, lw(20, 0, 0));                  // Squashed load-use pair
    add_word(3, addi(20, 20, 2));
    add_word(3, branch(F3_BNE, 18, 19, 8));
    add_word(3, addi(21, 0, 3));
    add_word(3, jal(22, 12));                   // At 28 jumping to 40
    add_word(3, addi(23, 0, 4));
    add_word(3, addi(23, 0, 5));
    add_word(3, addi(24, 0, 6));
    add_result(3, 18, 32'd5);
    add_result(3, 19, 32'd5);
    add_result(3, 21, 32'd3);
    add_result(3, 22, 32'd32);
    add_result(3, 24, 32'd6);
    // Program 4 mixes unreported writes with a move from x0
    add_word(4, addi(5, 0, 11));
    add_word(4, addi(26, 0, 22));
    add_word(4, addi(0, 0, 55));
    add_word(4, addi(25, 0, 0));
    add_word(4, alu_rr(F7_BASE, F3_ADD, 9, 5, 26));
    add_result(4, 25, 32'd0);
    add_result(4, 9,  32'd33);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks and bus tasks
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apply_reset();
    @(posedge clock);
    reset   <= 1'b1;
    start   <= 1'b0;
    psel    <= 1'b0;
    penable <= 1'b0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
  endtask

  task automatic apb_transfer(input logic write, input logic [`CORE_APB_ADDR_BITS-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int waited;
    rdata = '0;
    err   = 1'b0;
    if (hung) return;
    @(posedge clock);
    psel    <= 1'b1;                // SETUP
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clock);
    penable <= 1'b1;                // ACCESS
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (!pready && waited < APB_TIMEOUT);
    if (!pready) begin
      hung = 1'b1;
      $display("Timeout: APB transfer to %h never completed", addr);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_test();
    logic [31:0] rdata;
    logic        err;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      apb_transfer(1'b1, 12'(4 * i), fill_word(12'(4 * i)), rdata, err);
      check_value("fill write pslverr", 32'(err), 32'd0);
    end
    for (int i = 0; i < IMEM_WORDS; i++) begin
      apb_transfer(1'b0, 12'(4 * i), 32'd0, rdata, err);
      check_value("readback word", rdata, fill_word(12'(4 * i)));
      check_value("readback pslverr", 32'(err), 32'd0);
    end
    apb_transfer(1'b0, 12'h1F0, 32'd0, rdata, err);
    check_value("out of range read pslverr", 32'(err), 32'd1);
    apb_transfer(1'b1, 12'hF00, 32'hDEAD_BEEF, rdata, err);  // Would alias word 0
    check_value("out of range write pslverr", 32'(err), 32'd1);
    apb_transfer(1'b0, 12'h000, 32'd0, rdata, err);
    check_value("word 0 after refused write", rdata, fill_word(12'h000));
    @(posedge clock);
    start <= 1'b1;
    apb_transfer(1'b1, 12'h004, 32'h1234_5678, rdata, err);
    check_value("write while running pslverr", 32'(err), 32'd1);
    @(posedge clock);
    start <= 1'b0;
    apb_transfer(1'b0, 12'h004, 32'd0, rdata, err);
    check_value("word 1 after refused write", rdata, fill_word(12'h004));
  endtask

  task automatic run_program(input int p);
    logic [31:0] rdata;
    logic        err;
    int          addr;
    int          first;
    int          count;
    int          waited;
    if (hung) return;
    apply_reset();
    addr = 0;
    for (int i = 0; i < prog_num_q.size(); i++) begin
      if (prog_num_q[i] == p) begin
        apb_transfer(1'b1, 12'(addr), prog_word_q[i], rdata, err);
        check_value("program write pslverr", 32'(err), 32'd0);
        addr += 4;
      end
    end
    apb_transfer(1'b1, 12'(addr), jal(0, 0), rdata, err);   // Self-loop parks fetch
    first = 0;
    count = 0;
    for (int i = 0; i < exp_num_q.size(); i++) begin
      if (exp_num_q[i] < p) first++;
      if (exp_num_q[i] == p) count++;
    end
    exp_ptr = first;
    exp_end = first + count;
    @(posedge clock);
    start <= 1'b1;
    waited = 0;
    while (exp_ptr < exp_end && waited < PROG_TIMEOUT) begin
      @(posedge clock);
      waited++;
    end
    if (exp_ptr < exp_end) begin
      hung = 1'b1;
      $display("Timeout: program %0d gave %0d of %0d results", p, exp_ptr - first, count);
    end
    repeat (10) @(posedge clock);   // Window for stray writes
    start <= 1'b0;
  endtask

  task automatic run_test(input int t);
    int errors_before;
    errors_before = errors;
    if (t == 0) begin
      apb_test();
    end else begin
      run_program(t);
    end
    if (errors != errors_before || hung) begin
      tests_failed++;
      $display("Test %0d %s: failed", t, test_title(t));
    end else begin
      $display("Test %0d %s: ok", t, test_title(t));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Result port monitor sampling mid-cycle
  always @(negedge clock) begin
    if (!reset && result_valid) begin
      assert (exp_ptr < exp_end) else begin
        errors++;
        $display("ERR %0t: unexpected result x%0d = %h", $time, result_reg, result_data);
      end
      if (exp_ptr < exp_end) begin
        check_value("result register", 32'(result_reg), exp_reg_q[exp_ptr]);
        check_value("result data", result_data, exp_val_q[exp_ptr]);
        exp_ptr++;
      end
    end
  end

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    start        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    exp_ptr      = 0;
    exp_end      = 0;
    errors       = 0;
    tests_failed = 0;
    hung         = 1'b0;
    build_tables();
    apply_reset();
    for (int t = 0; t <= NUM_PROGS; t++) begin
      run_test(t);
    end
    $display("Summary: %0d tests, %0d failed, %0d errors", NUM_PROGS + 1, tests_failed,
             errors);
    if (errors == 0 && !hung) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
src/isa_pkg.sv
src/pipe_pkg.sv
src/imem_apb.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_writeback.sv
src/riscv_core.sv
testbench/core_assert.sv
testbench/core_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module core_tb -f verilog.f -o core_tb_sim \
  && ./obj_dir/core_tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx '\*\* PASS \*\*' sim.log && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
